//--- Makefile
# Verilator build and run for the pipelined divider testbench.

VERILATOR  ?= verilator
TOP        ?= tb_pipelined_divider
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= PASS: all tests
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Operand and result width.
`define DIV_WIDTH 32

// One restoring step per quotient bit.
`define DIV_STAGES 32

// Tag carried alongside each division.
`define DIV_ADDR_WIDTH 8

`define DIV_OP_WIDTH 4

// Any other opcode selects the remainder.
`define DIV_OP_QUOTIENT 4'h1

`endif

//--- src/div_issue.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_issue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  div_pkg::operand_t     dividend,
    input  div_pkg::operand_t     divisor,
    input  div_pkg::addr_t        phys_addr,
    input  div_pkg::operand_t     pc,
    input  div_pkg::div_op_t      op,
    output div_pkg::div_stage_t   stage_in
);

    logic divisor_zero;
    div_pkg::work_t first_work;

    assign divisor_zero = (divisor == '0);

    // Dividend enters pre-shifted so the first step sees its top bit.
    always_comb begin
        if (divisor_zero) begin
            first_work = '0;
        end else begin
            first_work = {{(`DIV_WIDTH-1){1'b0}}, dividend, 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_in.valid <= 1'b0;
        end else begin
            stage_in.valid <= start;
        end
    end

    // Payload only moves when an operation is issued.
    always_ff @(posedge clk) begin
        if (start) begin
            stage_in.div_zero  <= divisor_zero;
            stage_in.work      <= first_work;
            stage_in.divisor   <= divisor;
            stage_in.op        <= op;
            stage_in.phys_addr <= phys_addr; // Tag rides along.
            stage_in.pc        <= pc;
        end
    end

endmodule

//--- src/div_pkg.sv
`include "div_defs.svh"

package div_pkg;

    typedef logic [`DIV_WIDTH-1:0] operand_t;
    typedef logic [`DIV_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DIV_OP_WIDTH-1:0] div_op_t;

    // Partial remainder in the upper half, quotient shifts in from the bottom.
    typedef logic [2*`DIV_WIDTH-1:0] work_t;

    typedef struct packed {
        logic valid;
        logic div_zero;
        work_t work;
        operand_t divisor;
        div_op_t op;
        addr_t phys_addr;
        operand_t pc;
    } div_stage_t;

    // One restoring step on the working word.
    function automatic work_t div_step(
        input work_t work,
        input operand_t divisor
    );
        work_t next;
        next = work;
        if (work[2*`DIV_WIDTH-1:`DIV_WIDTH] >= divisor) begin
            next[2*`DIV_WIDTH-1:`DIV_WIDTH] = work[2*`DIV_WIDTH-1:`DIV_WIDTH] - divisor;
            next[0] = 1'b1; // Quotient bit set.
        end else begin
            next[0] = 1'b0; // Restore, no subtraction.
        end
        return next;
    endfunction

endpackage

//--- src/div_result_select.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_result_select (
    input  div_pkg::div_stage_t   stage_out,
    output div_pkg::operand_t     result,
    output logic                  done,
    output logic                  divide_zero_exception,
    output div_pkg::addr_t        phys_addr_out,
    output div_pkg::operand_t     pc_out
);

    div_pkg::work_t final_work;

    // Last of the DIV_STAGES steps, no register after it.
    assign final_work = div_pkg::div_step(stage_out.work, stage_out.divisor);

    always_comb begin
        if (stage_out.div_zero) begin
            // Zero divisor sets every quotient bit, so force zero here.
            result = '0;
        end else if (stage_out.op == `DIV_OP_QUOTIENT) begin
            result = final_work[`DIV_WIDTH-1:0];
        end else begin
            result = final_work[2*`DIV_WIDTH-1:`DIV_WIDTH]; // Remainder.
        end
    end

    assign done = stage_out.valid;

    // Flag is only meaningful alongside done.
    assign divide_zero_exception = stage_out.valid & stage_out.div_zero;

    assign phys_addr_out = stage_out.phys_addr;
    assign pc_out        = stage_out.pc;

endmodule

//--- src/div_step_chain.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_step_chain (
    input  logic                  clk,
    input  logic                  reset,
    input  div_pkg::div_stage_t   stage_in,
    output div_pkg::div_stage_t   stage_out
);

    // Entry 0 is the issue register; the last entry feeds the final step.
    div_pkg::div_stage_t chain [`DIV_STAGES];

    assign chain[0] = stage_in;

    genvar i;
    generate
        for (i = 0; i < `DIV_STAGES - 1; i = i + 1) begin : g_step
            div_pkg::work_t stepped;
            div_pkg::div_stage_t stage_q;

            assign stepped = div_pkg::div_step(chain[i].work, chain[i].divisor);

            always_ff @(posedge clk) begin
                if (reset) begin
                    stage_q.valid <= 1'b0;
                end else begin
                    stage_q.valid <= chain[i].valid;
                end
            end

            always_ff @(posedge clk) begin
                stage_q.div_zero  <= chain[i].div_zero;
                // Shift up so the next dividend bit reaches the remainder half.
                stage_q.work      <= {stepped[2*`DIV_WIDTH-2:0], 1'b0};
                stage_q.divisor   <= chain[i].divisor;
                stage_q.op        <= chain[i].op;
                stage_q.phys_addr <= chain[i].phys_addr;
                stage_q.pc        <= chain[i].pc;
            end

            assign chain[i+1] = stage_q;
        end
    endgenerate

    assign stage_out = chain[`DIV_STAGES-1];

endmodule

//--- src/pipelined_divider.sv
`timescale 1ns/1ps

module pipelined_divider (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  div_pkg::operand_t     dividend,
    input  div_pkg::operand_t     divisor,
    input  div_pkg::addr_t        phys_addr,
    input  div_pkg::operand_t     pc,
    input  div_pkg::div_op_t      op,
    output div_pkg::operand_t     result,
    output logic                  done,
    output logic                  divide_zero_exception,
    output div_pkg::addr_t        phys_addr_out,
    output div_pkg::operand_t     pc_out
);

    div_pkg::div_stage_t stage_in;
    div_pkg::div_stage_t stage_out;

    // Issue register, first cycle of the pipe.
    div_issue div_issue_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .phys_addr (phys_addr),
        .pc        (pc),
        .op        (op),
        .stage_in  (stage_in)
    );

    div_step_chain div_step_chain_inst (
        .clk       (clk),
        .reset     (reset),
        .stage_in  (stage_in),
        .stage_out (stage_out)
    );

    // Combinational tail, done appears in the same cycle as stage_out.
    div_result_select div_result_select_inst (
        .stage_out             (stage_out),
        .result                (result),
        .done                  (done),
        .divide_zero_exception (divide_zero_exception),
        .phys_addr_out         (phys_addr_out),
        .pc_out                (pc_out)
    );

endmodule

//--- testbench/div_checker.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  div_pkg::operand_t     dividend,
    input  div_pkg::operand_t     divisor,
    input  div_pkg::addr_t        phys_addr,
    input  div_pkg::operand_t     pc,
    input  div_pkg::div_op_t      op,
    input  div_pkg::operand_t     result,
    input  logic                  done,
    input  logic                  divide_zero_exception,
    input  div_pkg::addr_t        phys_addr_out,
    input  div_pkg::operand_t     pc_out,
    input  logic                  report_req,
    output logic                  reported,
    output int                    value_errors,
    output int                    protocol_errors,
    output int                    pending
);

    // One entry per start, oldest first.
    div_pkg::operand_t exp_result_q [$];
    logic exp_exc_q [$];
    div_pkg::addr_t exp_addr_q [$];
    div_pkg::operand_t exp_pc_q [$];
    int due_q [$];

    int cycle;
    int checked;
    div_pkg::operand_t expected;

    initial begin
        reported = 1'b0;
        value_errors = 0;
        protocol_errors = 0;
        pending = 0;
        cycle = 0;
        checked = 0;
    end

    task automatic compare_field(
        input string name,
        input logic [31:0] got,
        input logic [31:0] want
    );
        if (got !== want) begin
            value_errors = value_errors + 1;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h (pc 0x%08h)",
                     name, got, want, exp_pc_q[0]);
        end
    endtask

    task automatic drop_front();
        void'(exp_result_q.pop_front());
        void'(exp_exc_q.pop_front());
        void'(exp_addr_q.pop_front());
        void'(exp_pc_q.pop_front());
        void'(due_q.pop_front());
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!reset) begin
            if (done) begin
                if (due_q.size() == 0) begin
                    protocol_errors = protocol_errors + 1;
                    $display("Unexpected done at cycle %0d with no pending start", cycle);
                end else begin
                    if (due_q[0] != cycle) begin
                        protocol_errors = protocol_errors + 1;
                        $display("done came at cycle %0d but was due at cycle %0d",
                                 cycle, due_q[0]);
                    end
                    compare_field("result", result, exp_result_q[0]);
                    compare_field("divide_zero_exception", {31'd0, divide_zero_exception},
                                  {31'd0, exp_exc_q[0]});
                    compare_field("phys_addr_out", {24'd0, phys_addr_out},
                                  {24'd0, exp_addr_q[0]});
                    compare_field("pc_out", pc_out, exp_pc_q[0]);
                    checked = checked + 1;
                    drop_front();
                end
            end else if (due_q.size() != 0 && due_q[0] == cycle) begin
                protocol_errors = protocol_errors + 1;
                $display("Missing done for pc 0x%08h, expected at cycle %0d",
                         exp_pc_q[0], due_q[0]);
                drop_front();
            end

            if (start) begin
                if (divisor == '0) begin
                    expected = '0; // Zero divisor gives a zero result.
                end else if (op == `DIV_OP_QUOTIENT) begin
                    expected = dividend / divisor;
                end else begin
                    expected = dividend % divisor;
                end
                exp_result_q.push_back(expected);
                exp_exc_q.push_back(divisor == '0);
                exp_addr_q.push_back(phys_addr);
                exp_pc_q.push_back(pc);
                due_q.push_back(cycle + `DIV_STAGES);
            end

            if (report_req && !reported) begin
                $display("Checker summary: %0d results checked, %0d value errors, %0d %s",
                         checked, value_errors, protocol_errors, "protocol errors");
                reported = 1'b1;
            end
        end
        pending = due_q.size();
    end

endmodule

//--- testbench/tb_pipelined_divider.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module tb_pipelined_divider;

    localparam int MAX_ENTRIES = 64;
    localparam int NUM_RANDOM = 40;

    logic clk;
    logic reset;
    logic start;
    div_pkg::operand_t dividend;
    div_pkg::operand_t divisor;
    div_pkg::addr_t phys_addr;
    div_pkg::operand_t pc;
    div_pkg::div_op_t op;
    div_pkg::operand_t result;
    logic done;
    logic divide_zero_exception;
    div_pkg::addr_t phys_addr_out;
    div_pkg::operand_t pc_out;

    logic report_req;
    logic reported;
    int value_errors;
    int protocol_errors;
    int pending;

    div_pkg::operand_t tbl_dividend [MAX_ENTRIES];
    div_pkg::operand_t tbl_divisor [MAX_ENTRIES];
    div_pkg::div_op_t tbl_op [MAX_ENTRIES];
    div_pkg::addr_t tbl_addr [MAX_ENTRIES];
    div_pkg::operand_t tbl_pc [MAX_ENTRIES];
    int tbl_gap [MAX_ENTRIES];
    int num_entries;
    int gap_sum;
    int run_limit;
    int run_cycles;
    integer seed;

    pipelined_divider pipelined_divider_inst (
        .clk                   (clk),
        .reset                 (reset),
        .start                 (start),
        .dividend              (dividend),
        .divisor               (divisor),
        .phys_addr             (phys_addr),
        .pc                    (pc),
        .op                    (op),
        .result                (result),
        .done                  (done),
        .divide_zero_exception (divide_zero_exception),
        .phys_addr_out         (phys_addr_out),
        .pc_out                (pc_out)
    );

    div_checker div_checker_inst (
        .clk                   (clk),
        .reset                 (reset),
        .start                 (start),
        .dividend              (dividend),
        .divisor               (divisor),
        .phys_addr             (phys_addr),
        .pc                    (pc),
        .op                    (op),
        .result                (result),
        .done                  (done),
        .divide_zero_exception (divide_zero_exception),
        .phys_addr_out         (phys_addr_out),
        .pc_out                (pc_out),
        .report_req            (report_req),
        .reported              (reported),
        .value_errors          (value_errors),
        .protocol_errors       (protocol_errors),
        .pending               (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Tag is derived from the entry index so every entry is distinct.
    task automatic add_entry(
        input div_pkg::operand_t a,
        input div_pkg::operand_t b,
        input div_pkg::div_op_t code,
        input int gap
    );
        tbl_dividend[num_entries] = a;
        tbl_divisor[num_entries] = b;
        tbl_op[num_entries] = code;
        tbl_addr[num_entries] = num_entries[7:0] ^ 8'h5A;
        tbl_pc[num_entries] = 32'h0000_4000 + num_entries * 4;
        tbl_gap[num_entries] = gap;
        num_entries = num_entries + 1;
    endtask

    task automatic add_random_entries();
        div_pkg::operand_t r_dividend;
        div_pkg::operand_t r_divisor;
        logic [31:0] r_ctrl;
        div_pkg::div_op_t r_op;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            r_dividend = $random(seed);
            r_divisor = $random(seed);
            r_ctrl = $random(seed);
            if (r_ctrl[2:0] == 3'd0) begin
                r_divisor = '0; // Roughly one in eight divides by zero.
            end else if (r_ctrl[3]) begin
                r_divisor = r_divisor >> r_ctrl[8:4]; // Small divisors, large quotients.
            end
            r_op = r_ctrl[9] ? 4'h1 : r_ctrl[13:10];
            if (r_ctrl[15:14] == 2'd0) begin
                add_entry(r_dividend, r_divisor, r_op, {30'd0, r_ctrl[17:16]});
            end else begin
                add_entry(r_dividend, r_divisor, r_op, 0);
            end
        end
    endtask

    task automatic apply_entry(input int idx);
        start = 1'b1;
        dividend = tbl_dividend[idx];
        divisor = tbl_divisor[idx];
        op = tbl_op[idx];
        phys_addr = tbl_addr[idx];
        pc = tbl_pc[idx];
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (tbl_gap[idx]) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        dividend = '0;
        divisor = '0;
        phys_addr = '0;
        pc = '0;
        op = '0;
        report_req = 1'b0;
        seed = 44416;
        num_entries = 0;

        add_entry(32'd100, 32'd7, 4'h1, 0);
        add_entry(32'd5, 32'd9, 4'h1, 0); // Dividend below divisor.
        add_entry(32'd1234, 32'd1234, 4'h1, 0);
        add_entry(32'hDEADBEEF, 32'd1, 4'h1, 0);
        add_entry(32'hFFFFFFFF, 32'd1, 4'h1, 1);
        add_entry(32'hFFFFFFFF, 32'hFFFFFFFF, 4'h1, 0);
        add_entry(32'h80000000, 32'd3, 4'h1, 2);
        add_entry(32'd100, 32'd7, 4'h0, 0);
        add_entry(32'hFFFFFFFF, 32'd10, 4'h2, 0);
        add_entry(32'd12345678, 32'd256, 4'hF, 0);
        add_entry(32'd5, 32'd9, 4'h0, 3);
        add_entry(32'd0, 32'd0, 4'h1, 0); // Zero divisors.
        add_entry(32'd77, 32'd0, 4'h1, 0);
        add_entry(32'hFFFFFFFF, 32'd0, 4'h0, 40); // Pipe fully drains.
        add_entry(32'h7FFFFFFF, 32'h00010000, 4'h1, 0);
        add_entry(32'h12345678, 32'h00000010, 4'h2, 0);
        add_entry(32'd1000, 32'd3, 4'h1, 0);
        add_entry(32'd1000, 32'd3, 4'hF, 0);
        add_entry(32'hCAFEF00D, 32'h0000BEEF, 4'h0, 0);
        add_entry(32'd0, 32'd5, 4'h1, 5);
        add_random_entries();

        gap_sum = 0;
        for (int i = 0; i < num_entries; i++) begin
            gap_sum = gap_sum + tbl_gap[i];
        end
        run_limit = num_entries + gap_sum + `DIV_STAGES + 20;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < num_entries; i++) begin
            apply_entry(i);
        end
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
        report_req = 1'b1;
        wait (reported == 1'b1);

        if (value_errors + protocol_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (reset) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
            if (run_cycles >= run_limit) begin
                $display("Timeout after %0d cycles, %0d results still pending", run_cycles,
                         pending);
                $display("FAIL: see errors above");
                $finish;
            end
        end
    end

endmodule

//--- verilog.f
+incdir+include
src/div_pkg.sv
src/div_issue.sv
src/div_step_chain.sv
src/div_result_select.sv
src/pipelined_divider.sv
testbench/div_checker.sv
testbench/tb_pipelined_divider.sv
